// ==== proc_pkg.sv ====
// shared widths, encodings, pipeline register structs and instruction decode; import into each stage
package proc_pkg;

    typedef logic [31:0] word_t;     // data word, instruction or word address
    typedef logic [4:0]  reg_idx_t;  // register index
    typedef logic [4:0]  opcode_t;   // instr[31:27]
    typedef logic [4:0]  alu_op_t;   // r-type function field
    typedef logic [1:0]  exc_t;      // overflow class, value doubles as status code

    // opcodes
    localparam opcode_t OP_RTYPE = 5'b00000;
    localparam opcode_t OP_J     = 5'b00001;
    localparam opcode_t OP_BNE   = 5'b00010;
    localparam opcode_t OP_JAL   = 5'b00011;
    localparam opcode_t OP_JR    = 5'b00100;
    localparam opcode_t OP_ADDI  = 5'b00101;
    localparam opcode_t OP_BLT   = 5'b00110;
    localparam opcode_t OP_SW    = 5'b00111;
    localparam opcode_t OP_LW    = 5'b01000;

    // alu functions
    localparam alu_op_t ALU_ADD = 5'd0;
    localparam alu_op_t ALU_SUB = 5'd1;
    localparam alu_op_t ALU_AND = 5'd2;
    localparam alu_op_t ALU_OR  = 5'd3;
    localparam alu_op_t ALU_SLL = 5'd4;
    localparam alu_op_t ALU_SRA = 5'd5;

    localparam reg_idx_t REG_RA     = 5'd31;  // link register for jal
    localparam reg_idx_t REG_STATUS = 5'd30;  // overflow code lands here

    localparam exc_t EXC_NONE = 2'd0;
    localparam exc_t EXC_ADD  = 2'd1;
    localparam exc_t EXC_ADDI = 2'd2;
    localparam exc_t EXC_SUB  = 2'd3;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;    // second alu input is the immediate
        logic    is_load;
        logic    is_store;
        logic    is_bne;
        logic    is_blt;
        logic    is_j;
        logic    is_jal;
        logic    is_jr;
        logic    reg_write;  // already cleared for rd == 0
        exc_t    can_ovf;    // which overflow this op can raise
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rb;  // read port b: rt, or rd for sw/bne/blt/jr
    } dec_t;

    typedef struct packed {
        word_t pc_plus1;
        word_t instr;
    } fd_reg_t;

    typedef struct packed {
        word_t    pc_plus1;
        ctrl_t    ctrl;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rb;
        reg_idx_t shamt;
        word_t    imm;    // sign extended, low 17 bits also rebuild the jump target
        word_t    a;      // port a value at decode
        word_t    b;      // port b value at decode
        logic     valid;  // low for a bubble
    } dx_reg_t;

    typedef struct packed {
        word_t    result;      // alu result, link address, status code or dmem address
        word_t    store_data;
        reg_idx_t dest;        // for a store this is its source register
        logic     reg_write;
        logic     is_load;
        logic     is_store;
    } xm_reg_t;

    typedef struct packed {
        word_t    wb_data;
        reg_idx_t dest;
        logic     reg_write;
        logic     is_load;
    } mw_reg_t;

    // what forwarding needs to know about a later stage
    typedef struct packed {
        reg_idx_t dest;
        logic     reg_write;
        logic     is_load;
    } fwd_src_t;

    function automatic dec_t decode_instr(word_t instr);
        dec_t    d;
        opcode_t op;
        logic    writes_rd;
        op        = instr[31:27];
        d         = '0;
        writes_rd = 1'b0;
        d.rd      = instr[26:22];
        d.rs      = instr[21:17];
        d.rb      = instr[16:12];  // rt by default
        case (op)
            OP_RTYPE: begin
                d.ctrl.alu_op = instr[6:2];
                writes_rd     = 1'b1;
                if (instr[6:2] == ALU_ADD) d.ctrl.can_ovf = EXC_ADD;
                if (instr[6:2] == ALU_SUB) d.ctrl.can_ovf = EXC_SUB;
            end
            OP_ADDI: begin
                d.ctrl.use_imm = 1'b1;
                d.ctrl.can_ovf = EXC_ADDI;
                writes_rd      = 1'b1;
            end
            OP_LW: begin
                d.ctrl.use_imm = 1'b1;   // address = rs + imm
                d.ctrl.is_load = 1'b1;
                writes_rd      = 1'b1;
            end
            OP_SW: begin
                d.ctrl.use_imm  = 1'b1;
                d.ctrl.is_store = 1'b1;
                d.rb            = d.rd;  // store data comes from rd
            end
            OP_BNE: begin
                d.ctrl.is_bne = 1'b1;
                d.rb          = d.rd;
            end
            OP_BLT: begin
                d.ctrl.is_blt = 1'b1;
                d.rb          = d.rd;
            end
            OP_J:   d.ctrl.is_j = 1'b1;
            OP_JAL: d.ctrl.is_jal = 1'b1;
            OP_JR: begin
                d.ctrl.is_jr = 1'b1;
                d.rb         = d.rd;     // jump address lives in rd
            end
            default: ;                   // unknown opcode acts as a nop
        endcase
        d.ctrl.reg_write = (writes_rd && d.rd != '0) || d.ctrl.is_jal;
        return d;
    endfunction

endpackage

// ==== fetch_stage.sv ====
// instruction fetch: pc register, redirect select and the f/d register, first stage of processor
module fetch_stage import proc_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic    clock,
    input  logic    rst_n,
    input  logic    redirect,     // taken branch or jump in execute
    input  word_t   redirect_pc,
    output word_t   address_imem,
    input  word_t   q_imem,       // combinational imem read
    output fd_reg_t fd
);

    word_t pc;
    word_t pc_plus1;

    assign pc_plus1     = pc + 32'd1;  // word addressed
    assign address_imem = pc;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
            fd <= '0;               // zero word decodes as a bubble
        end else begin
            pc <= redirect ? redirect_pc : pc_plus1;
            fd.pc_plus1 <= pc_plus1;
            // the word fetched under a taken redirect is squashed here
            fd.instr <= redirect ? '0 : q_imem;
        end
    end

endmodule

// ==== reg_file.sv ====
// 32 x 32 register file, two combinational reads and one write, used by decode and writeback
module reg_file import proc_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  reg_idx_t raddr_a,
    input  reg_idx_t raddr_b,
    output word_t    rdata_a,
    output word_t    rdata_b,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t regs [1:31];  // r0 has no storage

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;      // architectural state starts at zero
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // write data bypasses to a read of the same register in the same cycle
    always_comb begin
        if (raddr_a == '0)                   rdata_a = '0;
        else if (we && waddr == raddr_a)     rdata_a = wdata;
        else                                 rdata_a = regs[raddr_a];
        if (raddr_b == '0)                   rdata_b = '0;
        else if (we && waddr == raddr_b)     rdata_b = wdata;
        else                                 rdata_b = regs[raddr_b];
    end

    // decode clears reg_write for rd 0, so writeback never targets r0
    no_r0_write: assert property (@(posedge clock) disable iff (!rst_n) we |-> waddr != '0);

endmodule

// ==== decode_stage.sv ====
// instruction decode: control decode, register reads and the d/x register of processor
module decode_stage import proc_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  fd_reg_t  fd,
    input  logic     redirect,   // flush the instruction now in decode
    output reg_idx_t raddr_a,
    output reg_idx_t raddr_b,
    input  word_t    rdata_a,
    input  word_t    rdata_b,
    output dx_reg_t  dx
);

    dec_t dec;

    assign dec     = decode_instr(fd.instr);
    assign raddr_a = dec.rs;
    assign raddr_b = dec.rb;     // rt, or rd for store/branch/jr

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dx <= '0;
        end else if (redirect) begin
            dx <= '0;            // bubble: ctrl all zero, valid low
        end else begin
            dx.pc_plus1 <= fd.pc_plus1;
            dx.ctrl     <= dec.ctrl;
            dx.rd       <= dec.rd;
            dx.rs       <= dec.rs;
            dx.rb       <= dec.rb;
            dx.shamt    <= fd.instr[11:7];
            dx.imm      <= {{15{fd.instr[16]}}, fd.instr[16:0]};  // signed 17 bit field
            dx.a        <= rdata_a;
            dx.b        <= rdata_b;
            // an all-zero word is a nop or a squashed slot
            dx.valid    <= fd.instr != '0;
        end
    end

endmodule

// ==== forward_unit.sv ====
// operand bypass for execute: picks rs and port-b values from x/m, dmem, m/w or d/x
module forward_unit import proc_pkg::*; (
    input  dx_reg_t  dx,
    input  fwd_src_t xm_src,     // instruction now in memory
    input  fwd_src_t mw_src,     // instruction now in writeback
    input  word_t    xm_result,
    input  word_t    mw_data,    // value being written back
    input  word_t    q_dmem,     // load data of the memory-stage instruction
    output word_t    op_a,
    output word_t    op_b
);

    // youngest producer wins, a load in memory hands over its dmem data
    function automatic word_t pick(reg_idx_t idx, word_t dflt);
        logic hit_xm;
        logic hit_mw;
        hit_xm = xm_src.reg_write && xm_src.dest != '0 && xm_src.dest == idx;
        hit_mw = mw_src.reg_write && mw_src.dest != '0 && mw_src.dest == idx;
        if (hit_xm) return xm_src.is_load ? q_dmem : xm_result;
        if (hit_mw) return mw_data;
        return dflt;
    endfunction

    // always_comb so the struct inputs read inside pick stay in the sensitivity
    always_comb begin
        op_a = pick(dx.rs, dx.a);
        op_b = pick(dx.rb, dx.b);  // register value only, imm is chosen in execute
    end

endmodule

// ==== execute_stage.sv ====
// execute: alu, branch/jump resolution, overflow exception and the x/m register of processor
module execute_stage import proc_pkg::*; (
    input  logic    clock,
    input  logic    rst_n,
    input  dx_reg_t dx,
    input  word_t   op_a,         // forwarded rs value
    input  word_t   op_b,         // forwarded rt/rd value
    output logic    redirect,
    output word_t   redirect_pc,
    output xm_reg_t xm
);

    word_t    alu_b;
    word_t    alu_out;
    word_t    sum;
    word_t    diff;
    logic     ovf_add;
    logic     ovf_sub;
    logic     ovf;
    logic     br_taken;
    word_t    br_target;
    word_t    jmp_target;
    word_t    result;
    reg_idx_t dest;

    assign alu_b = dx.ctrl.use_imm ? dx.imm : op_b;
    assign sum   = op_a + alu_b;
    assign diff  = op_a - alu_b;

    always_comb begin
        case (dx.ctrl.alu_op)
            ALU_ADD: alu_out = sum;
            ALU_SUB: alu_out = diff;
            ALU_AND: alu_out = op_a & alu_b;
            ALU_OR:  alu_out = op_a | alu_b;
            ALU_SLL: alu_out = op_a << dx.shamt;
            ALU_SRA: alu_out = $signed(op_a) >>> dx.shamt;
            default: alu_out = '0;
        endcase
    end

    // signed overflow: operand signs agree (add) or differ (sub) and result sign flips
    assign ovf_add = (op_a[31] == alu_b[31]) && (sum[31] != op_a[31]);
    assign ovf_sub = (op_a[31] != alu_b[31]) && (diff[31] != op_a[31]);
    assign ovf     = (dx.ctrl.can_ovf == EXC_SUB) ? ovf_sub :
                     (dx.ctrl.can_ovf != EXC_NONE) && ovf_add;

    // bne/blt compare rd (port b) against rs (port a)
    assign br_taken = (dx.ctrl.is_bne && op_b != op_a)
                   || (dx.ctrl.is_blt && $signed(op_b) < $signed(op_a));
    assign br_target  = dx.pc_plus1 + dx.imm;
    assign jmp_target = {5'b0, dx.rd, dx.rs, dx.imm[16:0]};  // instr[26:0] zero extended

    // bubbles carry zero ctrl, so no valid gating is needed here
    assign redirect    = br_taken || dx.ctrl.is_j || dx.ctrl.is_jal || dx.ctrl.is_jr;
    assign redirect_pc = br_taken        ? br_target :
                         dx.ctrl.is_jr   ? op_b      :
                                           jmp_target;

    always_comb begin
        result = alu_out;
        dest   = dx.rd;               // also the source register of a store
        if (dx.ctrl.is_jal) begin
            result = dx.pc_plus1;     // link address
            dest   = REG_RA;
        end else if (ovf) begin
            result = word_t'(dx.ctrl.can_ovf);  // status code 1, 2 or 3
            dest   = REG_STATUS;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            xm <= '0;
        end else begin
            xm.result     <= result;
            xm.store_data <= op_b;    // forwarded rd value for sw
            xm.dest       <= dest;
            xm.reg_write  <= dx.ctrl.reg_write || ovf;  // overflow writes status even for rd 0
            xm.is_load    <= dx.ctrl.is_load;
            xm.is_store   <= dx.ctrl.is_store;
        end
    end

    // a squashed or nop slot must never steer fetch
    redirect_only_valid: assert property (@(posedge clock) disable iff (!rst_n)
        redirect |-> dx.valid);

endmodule

// ==== mem_wb_stage.sv ====
// memory access and writeback: dmem drive, store-data bypass, m/w register and regfile write
module mem_wb_stage import proc_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  xm_reg_t  xm,
    output word_t    address_dmem,
    output word_t    data,          // store data
    output logic     wren,
    input  word_t    q_dmem,        // combinational load data
    output mw_reg_t  mw,
    output logic     rf_we,
    output reg_idx_t rf_waddr,
    output word_t    rf_wdata
);

    logic wb_hit;

    assign address_dmem = xm.result;  // rs + imm for lw/sw
    assign wren         = xm.is_store;

    // xm.dest holds a store's source register; take the newer writeback value on a match
    assign wb_hit = mw.reg_write && mw.dest != '0 && mw.dest == xm.dest;
    assign data   = wb_hit ? mw.wb_data : xm.store_data;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mw <= '0;
        end else begin
            mw.wb_data   <= xm.is_load ? q_dmem : xm.result;
            mw.dest      <= xm.dest;
            mw.reg_write <= xm.reg_write;
            mw.is_load   <= xm.is_load;
        end
    end

    // register write happens at the edge ending writeback
    assign rf_we    = mw.reg_write;
    assign rf_waddr = mw.dest;
    assign rf_wdata = mw.wb_data;

    // decode never sets both load and store for one opcode
    no_load_store: assert property (@(posedge clock) disable iff (!rst_n)
        !(wren && xm.is_load));

endmodule

// ==== processor.sv ====
// top level of the five-stage core; connects stages, register file and bypass unit to imem/dmem
module processor import proc_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clock,
    input  logic  rst_n,
    output word_t address_imem,
    input  word_t q_imem,
    output word_t address_dmem,
    output word_t data,
    output logic  wren,
    input  word_t q_dmem
);

    fd_reg_t  fd;
    dx_reg_t  dx;
    xm_reg_t  xm;
    mw_reg_t  mw;
    logic     redirect;
    word_t    redirect_pc;
    reg_idx_t raddr_a;
    reg_idx_t raddr_b;
    word_t    rdata_a;
    word_t    rdata_b;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;
    word_t    op_a;
    word_t    op_b;
    fwd_src_t xm_src;
    fwd_src_t mw_src;

    // later-stage views for the bypass unit
    assign xm_src = '{dest: xm.dest, reg_write: xm.reg_write, is_load: xm.is_load};
    assign mw_src = '{dest: mw.dest, reg_write: mw.reg_write, is_load: mw.is_load};

    fetch_stage #(.RESET_PC(RESET_PC)) i_fetch (
        .clock, .rst_n, .redirect, .redirect_pc, .address_imem, .q_imem, .fd
    );

    decode_stage i_decode (
        .clock, .rst_n, .fd, .redirect, .raddr_a, .raddr_b, .rdata_a, .rdata_b, .dx
    );

    reg_file i_reg_file (
        .clock, .rst_n, .raddr_a, .raddr_b, .rdata_a, .rdata_b,
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    forward_unit i_forward (
        .dx, .xm_src, .mw_src, .xm_result(xm.result), .mw_data(rf_wdata), .q_dmem,
        .op_a, .op_b
    );

    execute_stage i_execute (
        .clock, .rst_n, .dx, .op_a, .op_b, .redirect, .redirect_pc, .xm
    );

    mem_wb_stage i_mem_wb (
        .clock, .rst_n, .xm, .address_dmem, .data, .wren, .q_dmem, .mw,
        .rf_we, .rf_waddr, .rf_wdata
    );

endmodule

// ==== tb_isa_model.svh ====
// testbench program builder, xorshift source and step-by-step ISA reference; included in tb_processor
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

function automatic word_t next_rand();
    rng_state ^= rng_state << 13;  // xorshift32
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

function automatic word_t enc_r(int rd, int rs, int rt, int shamt, alu_op_t fn);
    return {OP_RTYPE, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], fn, 2'b00};
endfunction

function automatic word_t enc_i(opcode_t op, int rd, int rs, int imm);
    return {op, rd[4:0], rs[4:0], imm[16:0]};
endfunction

function automatic void emit(word_t w);
    imem[prog_len] = w;
    prog_len++;
endfunction

// add/sub with the status-register exception, as the ISA defines it
function automatic void arith(logic [4:0] rd, word_t x, word_t y, logic sub, int code);
    word_t s;
    logic  ovf;
    s   = sub ? x - y : x + y;
    ovf = sub ? (x[31] != y[31] && s[31] != x[31]) : (x[31] == y[31] && s[31] != x[31]);
    if (ovf) ref_regs[30] = code;      // rd left alone
    else if (rd != 0) ref_regs[rd] = s;
endfunction

// one instruction at a time, no pipeline; collects expected stores in order
function automatic void run_reference();
    word_t      pc;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      imm;
    word_t      tgt;
    word_t      addr;
    logic [4:0] rd;
    logic [4:0] rs;
    pc = RESET_PC;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    for (int steps = 0; steps < 2000; steps++) begin
        ins  = imem[pc[7:0]];
        rd   = ins[26:22];
        rs   = ins[21:17];
        a    = ref_regs[rs];
        b    = ref_regs[ins[16:12]];
        imm  = {{15{ins[16]}}, ins[16:0]};
        tgt  = {5'b0, ins[26:0]};
        addr = a + imm;
        pc   = pc + 1;
        case (ins[31:27])
            OP_RTYPE: case (ins[6:2])
                ALU_ADD: arith(rd, a, b, 1'b0, 1);
                ALU_SUB: arith(rd, a, b, 1'b1, 3);
                ALU_AND: if (rd != 0) ref_regs[rd] = a & b;
                ALU_OR:  if (rd != 0) ref_regs[rd] = a | b;
                ALU_SLL: if (rd != 0) ref_regs[rd] = a << ins[11:7];
                ALU_SRA: if (rd != 0) ref_regs[rd] = $signed(a) >>> ins[11:7];
                default: ;
            endcase
            OP_ADDI: arith(rd, a, imm, 1'b0, 2);
            OP_LW:   if (rd != 0) ref_regs[rd] = ref_dmem[addr[7:0]];
            OP_SW: begin
                exp_addr.push_back(addr);
                exp_data.push_back(ref_regs[rd]);
                ref_dmem[addr[7:0]] = ref_regs[rd];
            end
            OP_BNE: if (ref_regs[rd] != a) pc = pc + imm;
            OP_BLT: if ($signed(ref_regs[rd]) < $signed(a)) pc = pc + imm;
            OP_J: begin
                if (tgt == pc - 1) return;  // parked in the final loop
                pc = tgt;
            end
            OP_JAL: begin
                ref_regs[31] = pc;
                pc = tgt;
            end
            OP_JR:   pc = ref_regs[rd];
            default: ;
        endcase
    end
endfunction

`endif

// ==== tb_processor.sv ====
// testbench for processor that runs a directed program and checks every dmem store against a reference
module tb_processor import proc_pkg::*; ();

    localparam word_t RESET_PC = '0;

    logic  clock;
    logic  rst_n;
    word_t address_imem;
    word_t q_imem;
    word_t address_dmem;
    word_t data;
    logic  wren;
    word_t q_dmem;

    word_t imem [256];
    word_t dmem [256];
    word_t ref_dmem [256];
    word_t ref_regs [32];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t rng_state = 32'hc23f0976;
    int    prog_len = 0;
    int    exp_idx = 0;
    int    cycles = 0;
    int    limit;
    int    jal_at;
    int    err_value = 0;   // wrong address or data
    int    err_store = 0;   // extra or missing stores
    int    err_time = 0;

    `include "tb_isa_model.svh"

    processor #(.RESET_PC(RESET_PC)) i_dut (
        .clock, .rst_n, .address_imem, .q_imem, .address_dmem, .data, .wren, .q_dmem
    );

    assign q_imem = imem[address_imem[7:0]];  // combinational reads
    assign q_dmem = dmem[address_dmem[7:0]];

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (wren) dmem[address_dmem[7:0]] <= data;
    end

    // compare process checks one expected pair per store
    always @(posedge clock) begin
        if (rst_n && wren) begin
            if (exp_idx >= exp_data.size()) begin
                $display("store to %h after all expected stores were seen", address_dmem);
                err_store++;
            end else begin
                assert (address_dmem == exp_addr[exp_idx]) else begin
                    $display("ERROR address_dmem got %h expected %h",
                             address_dmem, exp_addr[exp_idx]);
                    err_value++;
                end
                assert (data == exp_data[exp_idx]) else begin
                    $display("ERROR data got %h expected %h", data, exp_data[exp_idx]);
                    err_value++;
                end
                exp_idx++;
            end
        end
    end

    task automatic build_program();
        for (int i = 0; i < 256; i++) begin
            imem[i]     = '0;           // nops
            dmem[i]     = next_rand();
            ref_dmem[i] = dmem[i];
        end
        // dependent alu chain
        emit(enc_i(OP_ADDI, 1, 0, next_rand()));
        emit(enc_i(OP_ADDI, 2, 0, next_rand()));
        emit(enc_r(3, 1, 2, 0, ALU_ADD));
        emit(enc_r(4, 3, 1, 0, ALU_SUB));
        emit(enc_r(5, 4, 3, 0, ALU_AND));
        emit(enc_r(6, 5, 4, 0, ALU_OR));
        emit(enc_r(7, 6, 0, 3, ALU_SLL));
        emit(enc_r(8, 7, 0, 2, ALU_SRA));
        emit(enc_i(OP_ADDI, 9, 8, next_rand()));
        for (int r = 3; r <= 9; r++) emit(enc_i(OP_SW, r, 0, 64 + r));
        // load use and store of fresh values
        emit(enc_i(OP_LW, 10, 0, 5));
        emit(enc_r(11, 10, 1, 0, ALU_ADD));
        emit(enc_i(OP_SW, 11, 0, 80));
        emit(enc_i(OP_LW, 12, 0, 6));
        emit(enc_i(OP_SW, 12, 0, 81));
        emit(enc_i(OP_ADDI, 13, 12, 7));
        emit(enc_i(OP_SW, 13, 0, 82));
        emit(enc_i(OP_ADDI, 14, 0, 10));
        emit(enc_i(OP_LW, 15, 14, 3));
        emit(enc_i(OP_SW, 15, 14, 73));
        // branches taken and not taken with stores in both slots and at the target
        emit(enc_i(OP_ADDI, 16, 0, 5));
        emit(enc_i(OP_ADDI, 17, 0, -3));
        emit(enc_i(OP_BNE, 16, 17, 2));
        emit(enc_i(OP_SW, 16, 0, 100));
        emit(enc_i(OP_SW, 17, 0, 101));
        emit(enc_i(OP_SW, 16, 0, 102));
        emit(enc_i(OP_BNE, 16, 16, 2));
        emit(enc_i(OP_SW, 16, 0, 103));
        emit(enc_i(OP_SW, 17, 0, 104));
        emit(enc_i(OP_BLT, 17, 16, 2));
        emit(enc_i(OP_SW, 16, 0, 105));
        emit(enc_i(OP_SW, 17, 0, 106));
        emit(enc_i(OP_BLT, 16, 17, 2));
        emit(enc_i(OP_SW, 16, 0, 107));
        emit(enc_i(OP_SW, 17, 0, 108));
        // call and return with the jal target patched once the subroutine is placed
        jal_at = prog_len;
        emit('0);
        emit(enc_i(OP_SW, 18, 0, 113));
        // overflow on add, addi and sub
        emit(enc_i(OP_ADDI, 20, 0, 1));
        emit(enc_r(20, 20, 0, 31, ALU_SLL));   // 0x80000000
        emit(enc_i(OP_ADDI, 22, 0, 55));       // old rd value
        emit(enc_r(22, 20, 20, 0, ALU_ADD));   // most negative twice wraps
        emit(enc_i(OP_SW, 30, 0, 120));
        emit(enc_i(OP_SW, 22, 0, 121));
        emit(enc_i(OP_ADDI, 22, 20, -1));      // wraps to 0x7fffffff
        emit(enc_i(OP_SW, 30, 0, 122));
        emit(enc_i(OP_SW, 22, 0, 123));
        emit(enc_r(22, 20, 16, 0, ALU_SUB));   // 0x80000000 - 5
        emit(enc_i(OP_SW, 30, 0, 124));
        emit(enc_i(OP_SW, 22, 0, 125));
        emit({OP_J, 27'(prog_len)});           // park here
        imem[jal_at] = {OP_JAL, 27'(prog_len)};
        emit(enc_i(OP_SW, 31, 0, 112));
        emit(enc_i(OP_ADDI, 18, 0, 9));
        emit(enc_i(OP_JR, 31, 0, 0));
    endtask

    initial begin
        rst_n = 1'b0;
        build_program();
        run_reference();
        limit = 20 * prog_len;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        @(posedge clock);
        assert (address_imem == RESET_PC) else begin
            $display("ERROR address_imem got %h expected %h", address_imem, RESET_PC);
            err_value++;
        end
        while (exp_idx < exp_data.size() && cycles < limit) @(posedge clock);
        if (exp_idx < exp_data.size()) begin
            $display("timeout after %0d cycles, %0d of %0d stores seen",
                     cycles, exp_idx, exp_data.size());
            err_time++;
        end else begin
            repeat (20) @(posedge clock);     // room for stray stores
        end
        $display("errors: %0d value, %0d store, %0d timeout", err_value, err_store, err_time);
        if (err_value + err_store + err_time == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
proc_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
forward_unit.sv
execute_stage.sv
mem_wb_stage.sv
processor.sv
tb_processor.sv

// ==== Bender.yml ====
package:
  name: processor

sources:
  - proc_pkg.sv
  - fetch_stage.sv
  - reg_file.sv
  - decode_stage.sv
  - forward_unit.sv
  - execute_stage.sv
  - mem_wb_stage.sv
  - processor.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_processor.sv
